// File: source/f2_color_pkg.sv
package f2_color_pkg;

    //////////////////////////////////////////////////
    // Widths

    localparam int COLOR_INDEX_WIDTH  = 12;
    localparam int PRIORITY_WIDTH     = 2;
    localparam int NUM_LAYERS         = 3;   // Screen, sprites, second background
    localparam int CHANNEL_WIDTH      = 5;
    localparam int OUT_CHANNEL_WIDTH  = 8;
    localparam int PALETTE_WORD_WIDTH = 16;

    //////////////////////////////////////////////////
    // Layer dot

    // Transparent when index[3:0] is zero
    typedef struct packed {
        logic [PRIORITY_WIDTH-1:0]    prio;
        logic [COLOR_INDEX_WIDTH-1:0] index;
    } layer_dot_t;

    //////////////////////////////////////////////////
    // Palette word

    typedef struct packed {
        logic                     unused;   // Bit 15, ignored by the DAC
        logic [CHANNEL_WIDTH-1:0] blue;
        logic [CHANNEL_WIDTH-1:0] green;
        logic [CHANNEL_WIDTH-1:0] red;
    } rgb555_t;

    // CPU side sees raw data, video side sees channels
    typedef union packed {
        logic [PALETTE_WORD_WIDTH-1:0] raw;
        rgb555_t                       rgb;
    } palette_word_u;

endpackage

// File: source/pixel_bus_if.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Mixer to palette: winning colour index

interface index_if
    import f2_color_pkg::*;
();

    logic                         valid;   // One pulse per pixel
    logic [COLOR_INDEX_WIDTH-1:0] index;
    logic                         hblank;
    logic                         vblank;

    modport source (
        output valid,
        output index,
        output hblank,
        output vblank
    );

    modport sink (
        input  valid,
        input  index,
        input  hblank,
        input  vblank
    );

endinterface

//////////////////////////////////////////////////
// Palette to video output: looked-up colour

interface rgb_if
    import f2_color_pkg::*;
();

    logic          valid;
    palette_word_u color;
    logic          hblank;
    logic          vblank;

    modport source (
        output valid,
        output color,
        output hblank,
        output vblank
    );

    modport sink (
        input  valid,
        input  color,
        input  hblank,
        input  vblank
    );

endinterface

// File: source/layer_mixer.sv
`timescale 1ns/1ps

module layer_mixer
    import f2_color_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        pixel_valid,
    input  layer_dot_t [NUM_LAYERS-1:0] layer_dots,
    input  logic [NUM_LAYERS-1:0]       layer_enable,
    input  logic                        hblank_in,
    input  logic                        vblank_in,
    index_if.source                     out
);

    logic                         win_found;
    logic [PRIORITY_WIDTH-1:0]    win_prio;
    logic [COLOR_INDEX_WIDTH-1:0] win_index;

    // Enabled and not pen 0 of its 16-colour group
    function automatic logic is_candidate(
        input layer_dot_t dot,
        input logic       enable
    );
        return enable && (dot.index[3:0] != 4'd0);
    endfunction

    //////////////////////////////////////////////////
    // Priority select

    // Strict compare, so a tie stays with the lower layer
    always_comb begin
        win_found = 1'b0;
        win_prio  = '0;
        win_index = '0;   // Backdrop when nothing shows
        for (int i = 0; i < NUM_LAYERS; i++) begin
            if (is_candidate(layer_dots[i], layer_enable[i])) begin
                if (!win_found || (layer_dots[i].prio > win_prio)) begin
                    win_found = 1'b1;
                    win_prio  = layer_dots[i].prio;
                    win_index = layer_dots[i].index;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid  <= 1'b0;
            out.hblank <= 1'b1;
            out.vblank <= 1'b1;
        end else begin
            out.valid <= pixel_valid;   // Single pulse, no stall
            if (pixel_valid) begin
                out.hblank <= hblank_in;
                out.vblank <= vblank_in;
            end
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (pixel_valid) begin
            out.index <= win_index;
        end
    end

endmodule

// File: source/palette_ram.sv
`timescale 1ns/1ps

module palette_ram
    import f2_color_pkg::*;
#(
    parameter int PALETTE_ADDR_WIDTH = 12
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cpu_wr,
    input  logic [PALETTE_ADDR_WIDTH-1:0] cpu_addr,
    input  logic [1:0]                    cpu_be,
    input  logic [PALETTE_WORD_WIDTH-1:0] cpu_wdata,
    index_if.sink                         in,
    rgb_if.source                         out
);

    localparam int DEPTH = 1 << PALETTE_ADDR_WIDTH;

    logic [PALETTE_WORD_WIDTH-1:0] mem [DEPTH];
    logic [PALETTE_ADDR_WIDTH-1:0] rd_addr;

    // Small palettes drop the upper index bits
    assign rd_addr = in.index[PALETTE_ADDR_WIDTH-1:0];

    //////////////////////////////////////////////////
    // CPU write port

    always_ff @(posedge clk) begin
        if (cpu_wr) begin
            if (cpu_be[1]) begin
                mem[cpu_addr][15:8] <= cpu_wdata[15:8];   // Upper data strobe
            end
            if (cpu_be[0]) begin
                mem[cpu_addr][7:0] <= cpu_wdata[7:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Pixel read port

    // Same-cycle collision returns the old word
    always_ff @(posedge clk) begin
        if (in.valid) begin
            out.color.raw <= mem[rd_addr];
        end
    end

    // Control follows the read by one clock
    always_ff @(posedge clk) begin
        if (reset) begin
            out.valid  <= 1'b0;
            out.hblank <= 1'b1;
            out.vblank <= 1'b1;
        end else begin
            out.valid <= in.valid;
            if (in.valid) begin
                out.hblank <= in.hblank;
                out.vblank <= in.vblank;
            end
        end
    end

endmodule

// File: source/video_out.sv
`timescale 1ns/1ps

module video_out
    import f2_color_pkg::*;
(
    input  logic                         clk,
    input  logic                         reset,
    rgb_if.sink                          in,
    output logic [OUT_CHANNEL_WIDTH-1:0] red,
    output logic [OUT_CHANNEL_WIDTH-1:0] green,
    output logic [OUT_CHANNEL_WIDTH-1:0] blue,
    output logic                         hblank,
    output logic                         vblank,
    output logic                         video_valid
);

    logic blank;

    // 5 to 8 bits, top bits repeated into the LSBs
    function automatic logic [OUT_CHANNEL_WIDTH-1:0] widen(
        input logic [CHANNEL_WIDTH-1:0] c
    );
        return {c, c[CHANNEL_WIDTH-1 -: OUT_CHANNEL_WIDTH-CHANNEL_WIDTH]};
    endfunction

    assign blank = in.hblank | in.vblank;

    //////////////////////////////////////////////////
    // Output register

    always_ff @(posedge clk) begin
        if (reset) begin
            red         <= '0;
            green       <= '0;
            blue        <= '0;
            hblank      <= 1'b1;
            vblank      <= 1'b1;
            video_valid <= 1'b0;
        end else begin
            video_valid <= in.valid;
            if (in.valid) begin
                red    <= blank ? '0 : widen(in.color.rgb.red);   // Black in blanking
                green  <= blank ? '0 : widen(in.color.rgb.green);
                blue   <= blank ? '0 : widen(in.color.rgb.blue);
                hblank <= in.hblank;
                vblank <= in.vblank;
            end
        end
    end

endmodule

// File: source/f2_color_path.sv
`timescale 1ns/1ps

module f2_color_path
    import f2_color_pkg::*;
#(
    parameter int PALETTE_ADDR_WIDTH = 12
) (
    input  logic                          clk,
    input  logic                          reset,

    // Layer dots
    input  logic                          pixel_valid,
    input  layer_dot_t [NUM_LAYERS-1:0]   layer_dots,
    input  logic [NUM_LAYERS-1:0]         layer_enable,
    input  logic                          hblank_in,
    input  logic                          vblank_in,

    // CPU palette port
    input  logic                          cpu_wr,
    input  logic [PALETTE_ADDR_WIDTH-1:0] cpu_addr,
    input  logic [1:0]                    cpu_be,
    input  logic [PALETTE_WORD_WIDTH-1:0] cpu_wdata,

    // Video
    output logic [OUT_CHANNEL_WIDTH-1:0]  red,
    output logic [OUT_CHANNEL_WIDTH-1:0]  green,
    output logic [OUT_CHANNEL_WIDTH-1:0]  blue,
    output logic                          hblank,
    output logic                          vblank,
    output logic                          video_valid
);

    index_if mix_bus ();
    rgb_if   pal_bus ();

    //////////////////////////////////////////////////
    // Mixer, palette, output stage

    layer_mixer i_layer_mixer (
        .clk          (clk),
        .reset        (reset),
        .pixel_valid  (pixel_valid),
        .layer_dots   (layer_dots),
        .layer_enable (layer_enable),
        .hblank_in    (hblank_in),
        .vblank_in    (vblank_in),
        .out          (mix_bus.source)
    );

    palette_ram #(
        .PALETTE_ADDR_WIDTH (PALETTE_ADDR_WIDTH)
    ) i_palette_ram (
        .clk       (clk),
        .reset     (reset),
        .cpu_wr    (cpu_wr),
        .cpu_addr  (cpu_addr),
        .cpu_be    (cpu_be),
        .cpu_wdata (cpu_wdata),
        .in        (mix_bus.sink),
        .out       (pal_bus.source)
    );

    video_out i_video_out (
        .clk         (clk),
        .reset       (reset),
        .in          (pal_bus.sink),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .hblank      (hblank),
        .vblank      (vblank),
        .video_valid (video_valid)
    );

endmodule

// File: verification/f2_color_assertions.sv
`timescale 1ns/1ps

module f2_color_assertions
    import f2_color_pkg::*;
#(
    parameter int PALETTE_ADDR_WIDTH = 12
) (
    input logic                          clk,
    input logic                          reset,
    input logic                          pixel_valid,
    input layer_dot_t [NUM_LAYERS-1:0]   layer_dots,
    input logic [NUM_LAYERS-1:0]         layer_enable,
    input logic                          hblank_in,
    input logic                          vblank_in,
    input logic                          cpu_wr,
    input logic [PALETTE_ADDR_WIDTH-1:0] cpu_addr,
    input logic [1:0]                    cpu_be,
    input logic [PALETTE_WORD_WIDTH-1:0] cpu_wdata,
    input logic [OUT_CHANNEL_WIDTH-1:0]  red,
    input logic [OUT_CHANNEL_WIDTH-1:0]  green,
    input logic [OUT_CHANNEL_WIDTH-1:0]  blue,
    input logic                          hblank,
    input logic                          vblank,
    input logic                          video_valid
);

    int                            fail_count = 0;
    logic [PALETTE_WORD_WIDTH-1:0] shadow [1 << PALETTE_ADDR_WIDTH];
    logic [COLOR_INDEX_WIDTH-1:0]  exp_index;
    logic                          exp_blank1;
    logic                          exp_blank2;
    logic [PALETTE_WORD_WIDTH-1:0] exp_word;
    logic [23:0]                   exp_rgb;

    // Scan from the top layer down, so ties fall to the lowest number
    function automatic logic [COLOR_INDEX_WIDTH-1:0] pick_winner(
        input layer_dot_t [NUM_LAYERS-1:0] dots,
        input logic [NUM_LAYERS-1:0]       en
    );
        logic [COLOR_INDEX_WIDTH-1:0] idx;
        logic [PRIORITY_WIDTH-1:0]    best;
        logic                         any;
        idx  = '0;
        best = '0;
        any  = 1'b0;
        for (int i = NUM_LAYERS - 1; i >= 0; i--) begin
            if (en[i] && dots[i].index[3:0] != 4'd0 && (!any || dots[i].prio >= best)) begin
                any  = 1'b1;
                best = dots[i].prio;
                idx  = dots[i].index;
            end
        end
        return idx;
    endfunction

    //////////////////////////////////////////////////
    // Shadow palette and expected pipeline

    always_ff @(posedge clk) begin
        if (cpu_wr && cpu_be[1]) shadow[cpu_addr][15:8] <= cpu_wdata[15:8];
        if (cpu_wr && cpu_be[0]) shadow[cpu_addr][7:0] <= cpu_wdata[7:0];
        exp_index  <= pick_winner(layer_dots, layer_enable);
        exp_blank1 <= hblank_in | vblank_in;
        exp_word   <= shadow[exp_index[PALETTE_ADDR_WIDTH-1:0]];   // Old word on collision
        exp_blank2 <= exp_blank1;
        if (exp_blank2) begin
            exp_rgb <= '0;
        end else begin
            exp_rgb <= {exp_word[4:0], exp_word[4:2], exp_word[9:5], exp_word[9:7],
                        exp_word[14:10], exp_word[14:12]};
        end
    end

    a_valid_spacing: assert property (@(posedge clk) disable iff (reset)
        video_valid == $past(pixel_valid, 3))
        else begin $error("video_valid not three clocks after pixel_valid"); fail_count++; end

    a_blank_delay: assert property (@(posedge clk) disable iff (reset)
        video_valid |-> (hblank == $past(hblank_in, 3) && vblank == $past(vblank_in, 3)))
        else begin $error("blank flags not delayed by three clocks"); fail_count++; end

    a_rgb_value: assert property (@(posedge clk) disable iff (reset)
        video_valid |-> {red, green, blue} == exp_rgb)
        else begin $error("RGB %h, expected %h", {red, green, blue}, exp_rgb); fail_count++; end

endmodule

bind f2_color_path f2_color_assertions #(
    .PALETTE_ADDR_WIDTH (PALETTE_ADDR_WIDTH)
) i_checker (.*);

// File: verification/tb_f2_color_path.sv
`timescale 1ns/1ps

module tb_f2_color_path
    import f2_color_pkg::*;
();

    logic                          clk = 1'b0;
    logic                          reset = 1'b1;
    logic                          pixel_valid = 1'b0;
    layer_dot_t [NUM_LAYERS-1:0]   layer_dots = '0;
    logic [NUM_LAYERS-1:0]         layer_enable = '0;
    logic                          hblank_in = 1'b0;
    logic                          vblank_in = 1'b0;
    logic                          cpu_wr = 1'b0;
    logic [11:0]                   cpu_addr = '0;
    logic [1:0]                    cpu_be = '0;
    logic [PALETTE_WORD_WIDTH-1:0] cpu_wdata = '0;
    logic [OUT_CHANNEL_WIDTH-1:0]  red;
    logic [OUT_CHANNEL_WIDTH-1:0]  green;
    logic [OUT_CHANNEL_WIDTH-1:0]  blue;
    logic                          hblank;
    logic                          vblank;
    logic                          video_valid;
    logic [31:0] lfsr = 32'h8701;
    int pixels_sent = 0;
    int pixels_seen = 0;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] r;

    f2_color_path i_dut (.*);

    initial forever #5 clk = ~clk;

    always @(posedge clk) if (!reset && video_valid) pixels_seen++;

    // Galois LFSR, one step per bit
    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
        end
    endtask

    task automatic cpu_write(input logic [11:0] a, input logic [1:0] be, input logic [15:0] d);
        @(posedge clk) #1;
        {cpu_wr, cpu_addr, cpu_be, cpu_wdata} = {1'b1, a, be, d};
        @(posedge clk) #1;
        cpu_wr = 1'b0;
    endtask

    task automatic send_pixel(input layer_dot_t [NUM_LAYERS-1:0] dots,
                              input logic [NUM_LAYERS-1:0] en, input logic hb, input logic vb);
        @(posedge clk) #1;
        {pixel_valid, layer_dots, layer_enable, hblank_in, vblank_in} = {1'b1, dots, en, hb, vb};
        pixels_sent++;
    endtask

    // Drain the pipeline, then score the test
    task automatic finish_test(input string name, input int fails_before);
        int wait_cycles;
        @(posedge clk) #1;
        pixel_valid = 1'b0;
        wait_cycles = 0;
        while (pixels_seen != pixels_sent && wait_cycles < 20) begin
            @(posedge clk) #1;
            wait_cycles++;
        end
        repeat (4) @(posedge clk);
        #1;
        tests_run++;
        if (pixels_seen != pixels_sent) begin
            $display("Fail %s: expected %0d pixels, actual %0d", name, pixels_sent, pixels_seen);
            tests_failed++;
        end else if (i_dut.i_checker.fail_count != fails_before) begin
            $display("%s: %0d assertion failures", name, i_dut.i_checker.fail_count - fails_before);
            tests_failed++;
        end else begin
            $display("%s: ok", name);
        end
        pixels_sent = 0;
        pixels_seen = 0;
    endtask

    initial begin
        int                          f;
        layer_dot_t [NUM_LAYERS-1:0] dots;
        logic [11:0]                 addr;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        tests_run++;
        assert (!video_valid && hblank && vblank && red == '0 && green == '0 && blue == '0)
        else begin
            $display("Fail reset: expected 011 000000, actual %b%b%b %h%h%h",
                     video_valid, hblank, vblank, red, green, blue);
            tests_failed++;
        end

        ////////////////////////////////////////////////// Fill palette
        for (int a = 0; a < 4096; a++) begin
            random_bits(16, r);
            cpu_write(a[11:0], 2'b11, r[15:0]);
        end

        f = i_dut.i_checker.fail_count;
        for (int i = 0; i < 12; i++) begin
            send_pixel({2'b00, 12'h011, 2'b01, 12'h122, 2'b10, 12'h233}, 3'b111, 1'b0, 1'b0);
        end
        finish_test("spacing", f);

        f = i_dut.i_checker.fail_count;
        send_pixel({2'b01, 12'h301, 2'b01, 12'h402, 2'b01, 12'h503}, 3'b111, 1'b0, 1'b0);  // Tie
        send_pixel({2'b11, 12'h301, 2'b01, 12'h402, 2'b01, 12'h503}, 3'b011, 1'b0, 1'b0);
        send_pixel({2'b11, 12'h300, 2'b01, 12'h400, 2'b01, 12'h500}, 3'b111, 1'b0, 1'b0);
        for (int i = 0; i < 200; i++) begin
            random_bits(14, r);
            dots[0] = r[13:0];
            random_bits(14, r);
            dots[1] = r[13:0];
            random_bits(14, r);
            dots[2] = r[13:0];
            random_bits(3, r);
            send_pixel(dots, r[2:0], 1'b0, 1'b0);
        end
        finish_test("priority", f);

        f = i_dut.i_checker.fail_count;
        send_pixel({2'b00, 12'h011, 2'b00, 12'h022, 2'b11, 12'h0F1}, 3'b111, 1'b1, 1'b0);
        send_pixel({2'b00, 12'h011, 2'b00, 12'h022, 2'b11, 12'h0F1}, 3'b111, 1'b0, 1'b1);
        send_pixel({2'b00, 12'h011, 2'b00, 12'h022, 2'b11, 12'h0F1}, 3'b111, 1'b1, 1'b1);
        finish_test("blanking", f);

        f = i_dut.i_checker.fail_count;
        for (int i = 0; i < 40; i++) begin
            random_bits(12, r);
            if (r[3:0] == 4'd0) r[0] = 1'b1;
            addr = r[11:0];
            random_bits(17, r);
            cpu_write(addr, r[16] ? 2'b10 : 2'b01, r[15:0]);
            send_pixel({2'b00, 12'h000, 2'b00, 12'h000, 2'b11, addr}, 3'b001, 1'b0, 1'b0);
            @(posedge clk) #1;
            pixel_valid = 1'b0;   // One pixel per write
        end
        finish_test("byte_enable", f);

        $display("%0d tests, %0d failed", tests_run, tests_failed);
        if (tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: all.f
source/f2_color_pkg.sv
source/pixel_bus_if.sv
source/layer_mixer.sv
source/palette_ram.sv
source/video_out.sv
source/f2_color_path.sv
verification/f2_color_assertions.sv
verification/tb_f2_color_path.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the colour path testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_f2_color_path \
    -Mdir obj_dir \
    -f all.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_f2_color_path +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
